/* Makefile */
VERILATOR ?= verilator
TOP       ?= wbuf_tb
FILELIST  ?= wbuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* wbuf.f */
wbuf_pkg.sv
wbuf_push_seq.sv
wbuf_store.sv
wbuf_axi_drain.sv
wbuf_top.sv
wbuf_tb.sv

/* wbuf_axi_drain.sv */
/* writes the oldest line as one 8-beat burst, one burst in flight at a time
   the entry is retired by pop only after the write response */
module wbuf_axi_drain
    import wbuf_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  wb_entry_t head,
    input  logic      empty,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,
    output mem_wreq_t mem_req,
    output logic      pop
);

    drain_state_e         state;
    logic [BEAT_BITS-1:0] beat;
    wb_entry_t            line;
    logic                 last_beat;

    assign last_beat = (beat == BEAT_BITS'(LINE_WORDS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= D_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (!empty) begin
                        state <= D_ADDR;
                    end
                end
                D_ADDR: begin
                    if (awready) begin
                        state <= D_DATA;
                        beat  <= '0;
                    end
                end
                D_DATA: begin
                    if (wready) begin
                        if (last_beat) begin
                            state <= D_RESP;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                D_RESP: begin
                    if (bvalid) begin
                        state <= D_IDLE;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // snapshot of the head, later pushes may move it in the store
    always_ff @(posedge clk) begin
        if ((state == D_IDLE) && !empty) begin
            line <= head;
        end
    end

    always_comb begin
        mem_req = '0;
        case (state)
            D_ADDR: begin
                mem_req.awvalid = 1'b1;
                mem_req.awaddr  = line.addr;
            end
            D_DATA: begin
                mem_req.wvalid = 1'b1;
                mem_req.wdata  = line.data[beat*32 +: 32];
                mem_req.wlast  = last_beat;
            end
            D_RESP: begin
                mem_req.bready = 1'b1;
            end
            default: ;
        endcase
    end

    assign pop = (state == D_RESP) && bvalid;

endmodule

/* wbuf_cases.txt */
# P addr base | F addr base (push expected to block) | Q addr hit base
# S stall responses | G random stalls | W wait for burst in flight | D wait drained
G
P 00001000 10000000
P 00002000 20000000
P 00003000 30000000
D
S
P 00004000 40000000
W
Q 00004000 1 40000000
P 00005000 50000000
P 00004000 44000000
Q 00004000 1 44000000
Q 00005000 1 50000000
Q 0000dead 0 00000000
Q 00001000 0 00000000
P 00006000 60000000
F 00007000 70000000
G
D
Q 00004000 0 00000000
P 00008000 80000000
P 00009000 90000000
P 0000a000 a0000000
P 0000b000 b0000000
P 0000c000 c0000000
D

/* wbuf_pkg.sv */
/* shared types and sizes for the line write buffer
   lines are fixed at 8 x 32-bit words, no byte strobes or partial writes */
package wbuf_pkg;

    localparam int LINE_WORDS = 8;
    localparam int LINE_BITS = LINE_WORDS * 32;
    localparam int WB_DEPTH = 4;
    // count must reach WB_DEPTH itself
    localparam int CNT_BITS = 3;
    localparam int IDX_BITS = $clog2(WB_DEPTH);
    localparam int BEAT_BITS = $clog2(LINE_WORDS);

    // one buffered dirty line
    typedef struct packed {
        logic [31:0]          addr;
        logic [LINE_BITS-1:0] data;
    } wb_entry_t;

    // outgoing write channel strobes toward memory
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        wlast;
        logic        bready;
    } mem_wreq_t;

    typedef enum logic [1:0] {
        D_IDLE,
        D_ADDR,
        D_DATA,
        D_RESP
    } drain_state_e;

endpackage

/* wbuf_push_seq.sv */
/* accepts one line per handshake, at least 2 cycles per push
   in_line must stay stable while in_valid waits for in_ready */
module wbuf_push_seq
    import wbuf_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      in_valid,
    input  wb_entry_t in_line,
    input  logic      full,
    output logic      in_ready,
    output logic      push,
    output wb_entry_t push_entry
);

    typedef enum logic {
        S_IDLE,
        S_ACCEPT
    } push_state_e;

    push_state_e state;
    logic        accept;

    // take the line only when there is room
    assign accept = (state == S_IDLE) && in_valid && !full;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else if (accept) begin
            state <= S_ACCEPT;
        end else begin
            state <= S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_entry <= in_line;
        end
    end

    // store writes at the end of the accept cycle
    assign push     = (state == S_ACCEPT);
    assign in_ready = (state == S_ACCEPT);

endmodule

/* wbuf_store.sv */
/* shift array of WB_DEPTH lines, slot 0 newest, oldest at count-1
   push while full is not allowed; the sequencer checks full first */
module wbuf_store
    import wbuf_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 push,
    input  wb_entry_t            push_entry,
    input  logic                 pop,
    input  logic [31:0]          query_addr,
    output logic                 query_hit,
    output logic [LINE_BITS-1:0] query_data,
    output wb_entry_t            head,
    output logic                 empty,
    output logic                 full
);

    wb_entry_t             slot [WB_DEPTH];
    logic [CNT_BITS-1:0]   count;
    logic [WB_DEPTH-1:0]   slot_valid;
    logic [IDX_BITS-1:0]   head_idx;

    // new line enters at slot 0, the rest move one step older
    always_ff @(posedge clk) begin
        if (push) begin
            slot[0] <= push_entry;
            for (int i = 1; i < WB_DEPTH; i++) begin
                slot[i] <= slot[i-1];
            end
        end
    end

    // push and pop together leave the count alone
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    assign empty = (count == '0);
    assign full  = (count == CNT_BITS'(WB_DEPTH));

    always_comb begin
        for (int i = 0; i < WB_DEPTH; i++) begin
            slot_valid[i] = (CNT_BITS'(i) < count);
        end
    end

    // walk oldest to newest so the newest match is the one left
    always_comb begin
        query_hit  = 1'b0;
        query_data = '0;
        for (int i = WB_DEPTH - 1; i >= 0; i--) begin
            if (slot_valid[i] && (slot[i].addr == query_addr)) begin
                query_hit  = 1'b1;
                query_data = slot[i].data;
            end
        end
    end

    assign head_idx = empty ? '0 : IDX_BITS'(count - 1'b1);
    assign head     = slot[head_idx];

endmodule

/* wbuf_tb.sv */
/* runs the write buffer from wbuf_cases.txt, which is read from the project root
   the memory model acks bursts in order, one outstanding burst at a time */
module wbuf_tb
    import wbuf_pkg::*;
();

    localparam int PUSH_TIMEOUT  = 300;
    localparam int BLOCK_CYCLES  = 40;
    localparam int WAIT_TIMEOUT  = 3000;

    logic                 clk;
    logic                 rstn;
    logic                 in_valid;
    wb_entry_t            in_line;
    logic                 in_ready;
    logic [31:0]          query_addr;
    logic                 query_hit;
    logic [LINE_BITS-1:0] query_data;
    mem_wreq_t            mem_req;
    logic                 awready;
    logic                 wready;
    logic                 bvalid;

    integer      seed = 32'h2b72;
    int          errors = 0;
    int          timeouts = 0;
    int          checks = 0;
    int          bursts = 0;
    bit          aborted = 0;
    bit          mem_run = 0;
    bit          resp_pending = 0;
    bit          held = 0;
    logic [31:0] held_addr;
    logic [31:0] held_base;

    // lines in push order, the order memory must see them
    logic [31:0] exp_addr [$];
    logic [31:0] exp_base [$];

    logic [31:0] cap_addr;
    logic [31:0] cap_words [LINE_WORDS];
    int          cap_beats;

    wbuf_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_line    (in_line),
        .in_ready   (in_ready),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_data (query_data),
        .mem_req    (mem_req),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // word k of a line is base + k
    function automatic logic [LINE_BITS-1:0] line_data(input logic [31:0] base);
        logic [LINE_BITS-1:0] d;
        for (int k = 0; k < LINE_WORDS; k++) begin
            d[k*32 +: 32] = base + 32'(k);
        end
        return d;
    endfunction

    // stalled: address and data flow, response held back
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else if (mem_run) begin
            awready <= (($random(seed) & 3) != 0);
            wready  <= (($random(seed) & 3) != 0);
            bvalid  <= resp_pending && (($random(seed) & 1) != 0);
        end else begin
            awready <= 1'b1;
            wready  <= 1'b1;
            bvalid  <= 1'b0;
        end
    end

    task automatic check_burst();
        checks++;
        if (exp_addr.size() == 0) begin
            $display("** Error at %0t: burst to %h with no line pending", $time, cap_addr);
            errors++;
        end else begin
            if (cap_addr != exp_addr[0] || cap_beats != LINE_WORDS) begin
                $display("** Error at %0t: burst addr %h beats %0d, expected %h and %0d",
                         $time, cap_addr, cap_beats, exp_addr[0], LINE_WORDS);
                errors++;
            end
            for (int k = 0; k < LINE_WORDS; k++) begin
                if (cap_words[k] != exp_base[0] + 32'(k)) begin
                    $display("** Error at %0t: addr %h beat %0d data %h, expected %h",
                             $time, cap_addr, k, cap_words[k], exp_base[0] + 32'(k));
                    errors++;
                end
            end
            void'(exp_addr.pop_front());
            void'(exp_base.pop_front());
        end
        bursts++;
    endtask

    // memory side capture, sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (mem_req.awvalid && awready) begin
                cap_addr  = mem_req.awaddr;
                cap_beats = 0;
            end
            if (mem_req.wvalid && wready) begin
                if (mem_req.wlast != (cap_beats == LINE_WORDS - 1)) begin
                    $display("** Error at %0t: wlast %0b on beat %0d", $time,
                             mem_req.wlast, cap_beats);
                    errors++;
                end
                if (cap_beats < LINE_WORDS) begin
                    cap_words[cap_beats] = mem_req.wdata;
                end
                cap_beats++;
                if (mem_req.wlast) begin
                    resp_pending = 1'b1;
                end
            end
            if (mem_req.bready && bvalid) begin
                resp_pending = 1'b0;
                check_burst();
            end
        end
    end

    task automatic wait_ready(input logic [31:0] addr, input logic [31:0] base);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < PUSH_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready) begin
            exp_addr.push_back(addr);
            exp_base.push_back(base);
        end else begin
            $display("timeout: push of line %h never got in_ready, drain state %s",
                     addr, u_dut.u_drain.state.name());
            timeouts++;
            aborted = 1'b1;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic start_push(input logic [31:0] addr, input logic [31:0] base);
        @(posedge clk);
        in_valid     <= 1'b1;
        in_line.addr <= addr;
        in_line.data <= line_data(base);
    endtask

    // push held off by a full buffer, completed later by G
    task automatic blocked_push(input logic [31:0] addr, input logic [31:0] base);
        start_push(addr, base);
        for (int i = 0; i < BLOCK_CYCLES; i++) begin
            @(negedge clk);
            if (in_ready) begin
                $display("** Error at %0t: in_ready for %h while buffer full", $time, addr);
                errors++;
            end
        end
        checks++;
        held      = 1'b1;
        held_addr = addr;
        held_base = base;
    endtask

    task automatic lookup(input logic [31:0] addr, input logic hit, input logic [31:0] base);
        @(posedge clk);
        query_addr <= addr;
        @(negedge clk);
        checks++;
        if (query_hit != hit) begin
            $display("** Error at %0t: lookup %h hit %0b, expected %0b", $time, addr,
                     query_hit, hit);
            errors++;
        end else if (hit && query_data != line_data(base)) begin
            $display("** Error at %0t: lookup %h returned wrong line, expected base %h",
                     $time, addr, base);
            errors++;
        end
    endtask

    task automatic wait_in_flight();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!mem_req.bready && waited < WAIT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_req.bready) begin
            $display("timeout: no burst reached the response phase");
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_drained();
        int  waited;
        waited = 0;
        @(negedge clk);
        while ((exp_addr.size() != 0 || u_dut.u_drain.state != D_IDLE)
               && waited < WAIT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_addr.size() != 0 || u_dut.u_drain.state != D_IDLE) begin
            $display("timeout: %0d lines still unwritten, drain state %s",
                     exp_addr.size(), u_dut.u_drain.state.name());
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       text;
        logic [7:0]  op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        rstn       = 1'b0;
        in_valid   = 1'b0;
        in_line    = '0;
        query_addr = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        checks++;
        if (in_ready || mem_req.awvalid || mem_req.wvalid || mem_req.wlast ||
            mem_req.bready || query_hit) begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            errors++;
        end
        fd = $fopen("wbuf_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open wbuf_cases.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            n = $fgets(text, fd);
            if (n == 0 || text.len() < 2 || text[0] == "#") begin
                continue;
            end
            f1 = '0;
            f2 = '0;
            f3 = '0;
            n = $sscanf(text, "%c %h %h %h", op, f1, f2, f3);
            case (op)
                "P": begin
                    start_push(f1, f2);
                    wait_ready(f1, f2);
                end
                "F": blocked_push(f1, f2);
                "S": begin
                    @(negedge clk);
                    mem_run = 1'b0;
                end
                "G": begin
                    @(negedge clk);
                    mem_run = 1'b1;
                    if (held) begin
                        held = 1'b0;
                        wait_ready(held_addr, held_base);
                    end
                end
                "Q": lookup(f1, f2[0], f3);
                "W": wait_in_flight();
                "D": wait_drained();
                default: begin
                    $display("unknown operation in case file: %s", text);
                    errors++;
                end
            endcase
        end
        $display("checks=%0d bursts=%0d errors=%0d timeouts=%0d", checks, bursts,
                 errors, timeouts);
        if (errors == 0 && timeouts == 0 && !aborted) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* wbuf_top.sv */
/* write buffer between cache eviction path and memory write channel
   lookups are combinational and see a line until its write response */
module wbuf_top
    import wbuf_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  wb_entry_t            in_line,
    output logic                 in_ready,
    input  logic [31:0]          query_addr,
    output logic                 query_hit,
    output logic [LINE_BITS-1:0] query_data,
    output mem_wreq_t            mem_req,
    input  logic                 awready,
    input  logic                 wready,
    input  logic                 bvalid
);

    logic      full;
    logic      empty;
    logic      push;
    logic      pop;
    wb_entry_t push_entry;
    wb_entry_t head;

    wbuf_push_seq u_push (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_line    (in_line),
        .full       (full),
        .in_ready   (in_ready),
        .push       (push),
        .push_entry (push_entry)
    );

    wbuf_store u_store (
        .clk        (clk),
        .rstn       (rstn),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_data (query_data),
        .head       (head),
        .empty      (empty),
        .full       (full)
    );

    wbuf_axi_drain u_drain (
        .clk     (clk),
        .rstn    (rstn),
        .head    (head),
        .empty   (empty),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .mem_req (mem_req),
        .pop     (pop)
    );

endmodule
